//--- source/pktgen_pkg.sv
/* shared definitions for the packet generator.
   byte 0 of a beat sits in data[63:56] and empty counts the unused low bytes.
   the clock port is named reset and the async active-high reset is named clk */
package pktgen_pkg;

   // --------------------------------------------------
   // widths
   // --------------------------------------------------
   localparam int data_w  = 64;                 // stream beat width
   localparam int empty_w = 3;                  // unused bytes on eop
   localparam int addr_w  = 4;                  // host register address
   localparam int len_w   = 14;                 // payload length field
   localparam int prbs_w  = 23;                 // x^23 + x^18 + 1

   // --------------------------------------------------
   // register map
   // --------------------------------------------------
   localparam logic [addr_w-1:0] addr_num_packets    = 4'd0;
   localparam logic [addr_w-1:0] addr_payload_len    = 4'd1;
   localparam logic [addr_w-1:0] addr_random_payload = 4'd2;
   localparam logic [addr_w-1:0] addr_start          = 4'd3;
   localparam logic [addr_w-1:0] addr_stop           = 4'd4;
   localparam logic [addr_w-1:0] addr_sa_lo          = 4'd5;   // sa[31:0]
   localparam logic [addr_w-1:0] addr_sa_hi          = 4'd6;   // sa[47:32]
   localparam logic [addr_w-1:0] addr_da_lo          = 4'd7;
   localparam logic [addr_w-1:0] addr_da_hi          = 4'd8;
   localparam logic [addr_w-1:0] addr_tx_count       = 4'd9;   // read only
   localparam logic [addr_w-1:0] addr_prbs_seed      = 4'd10;

   // limits, applied when a frame begins
   localparam logic [len_w-1:0] min_payload_len = 14'd8;
   localparam logic [len_w-1:0] max_payload_len = 14'd1500;

   localparam logic [prbs_w-1:0] default_seed = 23'h5eed00;  // nonzero so prbs never locks
   localparam logic [31:0]       crc_poly_rev = 32'hedb88320; // reflected ethernet poly

   // --------------------------------------------------
   // structs
   // --------------------------------------------------
   typedef struct packed {
      logic               valid;
      logic               sop;
      logic               eop;
      logic [empty_w-1:0] empty;
      logic [data_w-1:0]  data;
   } st_beat_t;

   typedef struct packed {
      logic [31:0]       num_packets;
      logic [len_w-1:0]  payload_len;
      logic              random_payload;   // 0 incrementing, 1 prbs23
      logic [47:0]       da;
      logic [47:0]       sa;
      logic [prbs_w-1:0] seed;
      logic              stop;             // level, host clears it
   } pkt_cfg_t;

endpackage

//--- source/pktgen_csr.sv
/* host register bank. writes land on the next edge, reads return one cycle later.
   a start write while the generator is busy is dropped.
   the start address reads back the busy flag */
module pktgen_csr (
   input  logic                          reset,      // clock
   input  logic                          clk,        // async reset, active high
   input  logic [pktgen_pkg::addr_w-1:0] address,
   input  logic                          write,
   input  logic                          read,
   input  logic [31:0]                   writedata,
   input  logic                          frame_done,
   input  logic                          busy,
   output logic [31:0]                   readdata,
   output pktgen_pkg::pkt_cfg_t          cfg,
   output logic                          start
);

   logic [31:0] tx_count;  // frames sent since the last start
   logic        start_wr;

   // second write before busy rises is blocked by start itself
   assign start_wr = write && (address == pktgen_pkg::addr_start) && writedata[0] &&
                     !busy && !start;

   // --------------------------------------------------
   // configuration registers
   // --------------------------------------------------
   always_ff @(posedge reset or posedge clk) begin
      if (clk) begin
         cfg      <= '0;
         cfg.seed <= pktgen_pkg::default_seed;
      end else if (write) begin
         case (address)
            pktgen_pkg::addr_num_packets:    cfg.num_packets    <= writedata;
            pktgen_pkg::addr_payload_len:    cfg.payload_len    <= writedata[13:0];
            pktgen_pkg::addr_random_payload: cfg.random_payload <= writedata[0];
            pktgen_pkg::addr_stop:           cfg.stop           <= writedata[0];
            pktgen_pkg::addr_sa_lo:          cfg.sa[31:0]       <= writedata;
            pktgen_pkg::addr_sa_hi:          cfg.sa[47:32]      <= writedata[15:0];
            pktgen_pkg::addr_da_lo:          cfg.da[31:0]       <= writedata;
            pktgen_pkg::addr_da_hi:          cfg.da[47:32]      <= writedata[15:0];
            pktgen_pkg::addr_prbs_seed:      cfg.seed           <= writedata[22:0];
            default: ;                                          // start handled below
         endcase
      end
   end

   // start pulse and frame counter
   always_ff @(posedge reset or posedge clk) begin
      if (clk) begin
         start    <= 1'b0;
         tx_count <= '0;
      end else begin
         start <= start_wr;                                     // one cycle only
         if (start)           tx_count <= '0;
         else if (frame_done) tx_count <= tx_count + 32'd1;
      end
   end

   // --------------------------------------------------
   // read mux, independent of tx_ready
   // --------------------------------------------------
   always_ff @(posedge reset or posedge clk) begin
      if (clk) begin
         readdata <= '0;
      end else if (read) begin
         case (address)
            pktgen_pkg::addr_num_packets:    readdata <= cfg.num_packets;
            pktgen_pkg::addr_payload_len:    readdata <= {18'h0, cfg.payload_len};
            pktgen_pkg::addr_random_payload: readdata <= {31'h0, cfg.random_payload};
            pktgen_pkg::addr_start:          readdata <= {31'h0, busy};
            pktgen_pkg::addr_stop:           readdata <= {31'h0, cfg.stop};
            pktgen_pkg::addr_sa_lo:          readdata <= cfg.sa[31:0];
            pktgen_pkg::addr_sa_hi:          readdata <= {16'h0, cfg.sa[47:32]};
            pktgen_pkg::addr_da_lo:          readdata <= cfg.da[31:0];
            pktgen_pkg::addr_da_hi:          readdata <= {16'h0, cfg.da[47:32]};
            pktgen_pkg::addr_tx_count:       readdata <= tx_count;
            pktgen_pkg::addr_prbs_seed:      readdata <= {9'h0, cfg.seed};
            default:                         readdata <= '0;
         endcase
      end
   end

endmodule

//--- source/frame_sequencer.sv
/* frame FSM: idle, two header slots, payload slots, one gap slot, then back to idle.
   payload slots carry framing only, data is filled further down the pipe.
   the idle slot between frames keeps tx.valid low after an extra fcs beat */
module frame_sequencer (
   input  logic                 reset,     // clock
   input  logic                 clk,       // async reset, active high
   input  logic                 tx_ready,  // pipeline enable
   input  pktgen_pkg::pkt_cfg_t cfg,
   input  logic                 start,
   output pktgen_pkg::st_beat_t slot,
   output logic                 payload,
   output logic                 frame_done,
   output logic                 busy
);

   typedef enum logic [2:0] {st_idle, st_hdr0, st_hdr1, st_pay, st_gap} state_t;

   state_t                       state;
   logic                         run;        // frames still owed to the host
   logic [pktgen_pkg::len_w-1:0] plen;       // clamped length of this frame
   logic [pktgen_pkg::len_w-1:0] plen_clamp;
   logic [pktgen_pkg::len_w-1:0] rem;        // bytes not yet given a slot
   logic [15:0]                  seq_num;
   logic [31:0]                  frame_cnt;
   logic                         last_frame;

   always_comb begin
      if (cfg.payload_len < pktgen_pkg::min_payload_len)
         plen_clamp = pktgen_pkg::min_payload_len;
      else if (cfg.payload_len > pktgen_pkg::max_payload_len)
         plen_clamp = pktgen_pkg::max_payload_len;
      else
         plen_clamp = cfg.payload_len;
   end

   assign last_frame = (frame_cnt + 32'd1) >= cfg.num_packets;
   assign frame_done = tx_ready && (state == st_gap);   // one pulse per frame
   assign busy       = run || (state != st_idle);

   // --------------------------------------------------
   // state and slot registers
   // --------------------------------------------------
   always_ff @(posedge reset or posedge clk) begin
      if (clk) begin
         state     <= st_idle;
         run       <= 1'b0;
         slot      <= '0;
         payload   <= 1'b0;
         plen      <= '0;
         rem       <= '0;
         seq_num   <= '0;
         frame_cnt <= '0;
      end else if (start) begin
         run       <= (cfg.num_packets != 32'd0);            // zero packets sends nothing
         seq_num   <= '0;
         frame_cnt <= '0;
      end else if (tx_ready) begin
         slot    <= '0;                                      // invalid unless set below
         payload <= 1'b0;
         case (state)
            st_idle: if (run) begin
               plen  <= plen_clamp;                          // latched for the whole frame
               rem   <= plen_clamp;
               state <= st_hdr0;
            end
            st_hdr0: begin
               slot.valid <= 1'b1;
               slot.sop   <= 1'b1;
               slot.data  <= {cfg.da, cfg.sa[47:32]};
               state      <= st_hdr1;
            end
            st_hdr1: begin
               slot.valid <= 1'b1;
               slot.data  <= {cfg.sa[31:0], {2'b00, plen} + 16'd2, seq_num};
               state      <= st_pay;
            end
            st_pay: begin
               slot.valid <= 1'b1;
               payload    <= 1'b1;
               rem        <= rem - 14'd8;
               if (rem <= 14'd8) begin                       // last payload slot
                  slot.eop   <= 1'b1;
                  slot.empty <= 3'd0 - rem[2:0];             // (8 - P mod 8) mod 8
                  state      <= st_gap;
               end
            end
            st_gap: begin
               seq_num   <= seq_num + 16'd1;
               frame_cnt <= frame_cnt + 32'd1;
               if (last_frame || cfg.stop) run <= 1'b0;      // stop only at a frame boundary
               state     <= st_idle;
            end
            default: state <= st_idle;
         endcase
      end
   end

endmodule

//--- source/payload_source.sv
/* fills payload slots with incrementing bytes or prbs23 words, one cycle latency.
   prbs bits come out msb first, each new bit is s[22]^s[17] shifted in at bit 0.
   the prbs register only reloads on start, so the sequence runs on across frames */
module payload_source (
   input  logic                 reset,     // clock
   input  logic                 clk,       // async reset, active high
   input  logic                 tx_ready,
   input  pktgen_pkg::pkt_cfg_t cfg,
   input  logic                 start,
   input  pktgen_pkg::st_beat_t slot,
   input  logic                 payload,
   output pktgen_pkg::st_beat_t beat
);

   logic [pktgen_pkg::prbs_w-1:0]  prbs;
   logic [pktgen_pkg::prbs_w-1:0]  prbs_nxt;
   logic [pktgen_pkg::data_w-1:0]  prbs_bits;
   logic [pktgen_pkg::data_w-1:0]  inc_bits;
   logic [pktgen_pkg::data_w-1:0]  tail_mask;
   logic [7:0]                     byte_cnt;   // payload byte index mod 256
   pktgen_pkg::st_beat_t           beat_nxt;

   // 64 lfsr steps per beat
   always_comb begin
      prbs_nxt = prbs;
      prbs_bits = '0;
      for (int i = 0; i < pktgen_pkg::data_w; i++) begin
         prbs_nxt  = {prbs_nxt[21:0], prbs_nxt[22] ^ prbs_nxt[17]};
         prbs_bits = {prbs_bits[62:0], prbs_nxt[0]};
      end
   end

   always_comb begin
      for (int i = 0; i < 8; i++) inc_bits[63-8*i -: 8] = byte_cnt + 8'(i);
      tail_mask = slot.eop ? ({64{1'b1}} << {slot.empty, 3'b000}) : {64{1'b1}};
      beat_nxt = slot;                                   // headers and gaps pass through
      if (payload) beat_nxt.data = (cfg.random_payload ? prbs_bits : inc_bits) & tail_mask;
   end

   always_ff @(posedge reset or posedge clk) begin
      if (clk) begin
         beat     <= '0;
         byte_cnt <= '0;
         prbs     <= pktgen_pkg::default_seed;
      end else begin
         if (start)                                      prbs <= cfg.seed;
         else if (tx_ready && payload && cfg.random_payload) prbs <= prbs_nxt;
         if (tx_ready) begin
            beat <= beat_nxt;
            if (slot.sop)    byte_cnt <= '0;             // restart pattern per frame
            else if (payload) byte_cnt <= byte_cnt + 8'd8;
         end
      end
   end

endmodule

//--- source/fcs_inserter.sv
/* appends the ethernet crc32 after the last payload byte, one cycle latency.
   fcs goes out least significant crc byte first.
   with fewer than 4 empty bytes the next input beat must be invalid, it is
   replaced by the extra eop beat */
module fcs_inserter (
   input  logic                 reset,     // clock
   input  logic                 clk,       // async reset, active high
   input  logic                 tx_ready,
   input  pktgen_pkg::st_beat_t beat,
   output pktgen_pkg::st_beat_t tx
);

   logic [31:0]                   crc;       // running crc, not yet inverted
   logic [31:0]                   crc_nxt;
   logic [31:0]                   fcs;
   logic [31:0]                   fcs_be;    // fcs in wire byte order
   logic [3:0]                    nbytes;    // valid bytes in this beat
   logic [pktgen_pkg::data_w-1:0] keep_mask;
   logic [95:0]                   merged;    // eop beat plus spill room
   logic                          ext_pend;
   logic [pktgen_pkg::data_w-1:0] ext_data;
   logic [2:0]                    ext_empty;
   pktgen_pkg::st_beat_t          tx_nxt;

   // bytewise reflected crc, byte 0 first
   function automatic logic [31:0] crc_beat(input logic [31:0] c_in,
                                            input logic [63:0] d,
                                            input logic [3:0]  n);
      logic [31:0] c;
      c = c_in;
      for (int i = 0; i < 8; i++) begin
         if (i < int'(n)) begin
            c = c ^ {24'h0, d[63-8*i -: 8]};
            for (int j = 0; j < 8; j++) c = c[0] ? ((c >> 1) ^ pktgen_pkg::crc_poly_rev) : (c >> 1);
         end
      end
      return c;
   endfunction

   // --------------------------------------------------
   // crc and merge
   // --------------------------------------------------
   always_comb begin
      nbytes    = beat.eop ? (4'd8 - {1'b0, beat.empty}) : 4'd8;
      crc_nxt   = crc_beat(beat.sop ? 32'hffffffff : crc, beat.data, nbytes);
      fcs       = ~crc_nxt;                                   // final xor
      fcs_be    = {fcs[7:0], fcs[15:8], fcs[23:16], fcs[31:24]};
      keep_mask = {64{1'b1}} << {beat.empty, 3'b000};
      merged    = {beat.data & keep_mask, 32'h0} | ({fcs_be, 64'h0} >> {nbytes, 3'b000});

      tx_nxt = beat;                                          // default pass through
      if (beat.valid && beat.eop) begin
         tx_nxt.data = merged[95:32];
         if (beat.empty[2]) begin
            tx_nxt.empty = {1'b0, beat.empty[1:0]};           // fcs fits, empty - 4
         end else begin
            tx_nxt.eop   = 1'b0;                              // spill into extra beat
            tx_nxt.empty = '0;
         end
      end else if (ext_pend) begin
         tx_nxt.valid = 1'b1;
         tx_nxt.sop   = 1'b0;
         tx_nxt.eop   = 1'b1;
         tx_nxt.empty = ext_empty;
         tx_nxt.data  = ext_data;
      end
   end

   always_ff @(posedge reset or posedge clk) begin
      if (clk) begin
         crc      <= 32'hffffffff;
         ext_pend <= 1'b0;
         tx       <= '0;
      end else if (tx_ready) begin
         tx       <= tx_nxt;
         ext_pend <= beat.valid && beat.eop && !beat.empty[2];
         if (beat.valid) crc <= crc_nxt;
      end
   end

   // leftover fcs bytes, only read while ext_pend is set
   always_ff @(posedge reset) begin
      if (tx_ready && beat.valid && beat.eop) begin
         ext_data  <= {merged[31:0], 32'h0};
         ext_empty <= {1'b1, beat.empty[1:0]};                // 4 + empty
      end
   end

endmodule

//--- source/pktgen_top.sv
/* packet generator top: register bank feeding a three stage beat pipeline.
   tx_ready low freezes every stage, tx holds its value meanwhile */
module pktgen_top (
   input  logic                          reset,      // clock
   input  logic                          clk,        // async reset, active high
   input  logic [pktgen_pkg::addr_w-1:0] address,
   input  logic                          write,
   input  logic                          read,
   input  logic [31:0]                   writedata,
   input  logic                          tx_ready,
   output logic [31:0]                   readdata,
   output pktgen_pkg::st_beat_t          tx
);

   pktgen_pkg::pkt_cfg_t cfg;
   pktgen_pkg::st_beat_t slot;        // sequencer to payload source
   pktgen_pkg::st_beat_t beat;        // payload source to fcs
   logic                 start;
   logic                 payload;
   logic                 frame_done;
   logic                 busy;

   pktgen_csr u_csr (
      .reset(reset), .clk(clk), .address(address), .write(write), .read(read),
      .writedata(writedata), .frame_done(frame_done), .busy(busy),
      .readdata(readdata), .cfg(cfg), .start(start)
   );

   frame_sequencer u_seq (
      .reset(reset), .clk(clk), .tx_ready(tx_ready), .cfg(cfg), .start(start),
      .slot(slot), .payload(payload), .frame_done(frame_done), .busy(busy)
   );

   payload_source u_pay (
      .reset(reset), .clk(clk), .tx_ready(tx_ready), .cfg(cfg), .start(start),
      .slot(slot), .payload(payload), .beat(beat)
   );

   fcs_inserter u_fcs (
      .reset(reset), .clk(clk), .tx_ready(tx_ready), .beat(beat), .tx(tx)
   );

endmodule

//--- verification/pktgen_tb.sv
/* packet generator testbench, cases come from verification/pktgen_cases.txt.
   run from the project root so the cases path resolves.
   the port named reset is the clock, clk is the active-high async reset */
module pktgen_tb;
   timeunit 1ns;
   timeprecision 1ps;

   logic                          reset     = 1'b0;   // clock
   logic                          clk       = 1'b1;   // reset, held from time 0
   logic [pktgen_pkg::addr_w-1:0] address   = '0;
   logic                          write     = 1'b0;
   logic                          read      = 1'b0;
   logic [31:0]                   writedata = '0;
   logic                          tx_ready  = 1'b1;
   logic [31:0]                   readdata;
   pktgen_pkg::st_beat_t          tx;

   // case table, one entry per line of the cases file
   string       c_name[$];
   int          c_num[$];
   int          c_len[$];
   int          c_rnd[$];
   logic [31:0] c_seed[$];
   int          c_stop[$];

   // settings of the running case, the monitor reads them
   string       cur_name = "setup";
   int          cur_plen;
   logic        cur_rnd;
   logic [22:0] cur_seed;
   logic [47:0] cur_da;
   logic [47:0] cur_sa;
   int          frames_base;

   int          seed = 32'he28023bb;
   int          value_errors = 0;
   int          proto_errors = 0;
   int          frames_seen = 0;        // eop transfers since time 0
   int          frames_checked = 0;
   int          limit_ns = 0;
   logic        bp_on = 1'b0;           // random back-pressure enable
   logic        in_frame = 1'b0;
   logic        gap_due = 1'b0;         // eop went out, next beat must be idle
   logic [7:0]  rx_q[$];
   logic [7:0]  exp_q[$];
   logic [22:0] prbs_model;

   pktgen_top u_dut (
      .reset(reset), .clk(clk), .address(address), .write(write), .read(read),
      .writedata(writedata), .tx_ready(tx_ready), .readdata(readdata), .tx(tx)
   );

   always #2 reset = ~reset;                             // 4 ns period

   always @(posedge reset) tx_ready <= bp_on ? (($random(seed) & 3) != 0) : 1'b1;  // ~75%

   task automatic check_value(input string what, input logic [31:0] expected,
                              input logic [31:0] actual);
      if (expected !== actual) begin
         value_errors++;
         $display("[FAIL] %s: %s expected %0h actual %0h", cur_name, what, expected, actual);
      end
   endtask

   task automatic report_protocol(input string msg);
      proto_errors++;
      $display("error in case %s at %0t ns: %s", cur_name, $time, msg);
   endtask

   function automatic int clamp_len(input int len);
      if (len < int'(pktgen_pkg::min_payload_len)) return int'(pktgen_pkg::min_payload_len);
      if (len > int'(pktgen_pkg::max_payload_len)) return int'(pktgen_pkg::max_payload_len);
      return len;
   endfunction

   function automatic int frames_for(input int num, input int stop_after);
      if (stop_after > 0 && stop_after < num) return stop_after;
      return num;
   endfunction

   // --------------------------------------------------
   // reference model
   // --------------------------------------------------
   task automatic next_prbs_word(output logic [63:0] w);
      logic nb;
      w = '0;
      for (int i = 0; i < 64; i++) begin
         nb         = prbs_model[22] ^ prbs_model[17];  // x^23 + x^18 + 1
         prbs_model = {prbs_model[21:0], nb};
         w          = {w[62:0], nb};                    // first bit lands in the msb
      end
   endtask

   task automatic build_frame(input int seq);
      logic [63:0] w;
      logic [31:0] crc;
      logic [15:0] len_field;
      w         = '0;
      len_field = 16'(cur_plen + 2);
      exp_q.delete();
      for (int i = 5; i >= 0; i--) exp_q.push_back(cur_da[8*i +: 8]);
      for (int i = 5; i >= 0; i--) exp_q.push_back(cur_sa[8*i +: 8]);
      exp_q.push_back(len_field[15:8]);
      exp_q.push_back(len_field[7:0]);
      exp_q.push_back(8'(seq >> 8));
      exp_q.push_back(8'(seq));
      if (seq == 0) prbs_model = cur_seed;               // reloaded on start only
      for (int n = 0; n < cur_plen; n++) begin
         if (cur_rnd && (n % 8 == 0)) next_prbs_word(w); // one word per payload beat
         exp_q.push_back(cur_rnd ? w[63-8*(n%8) -: 8] : 8'(n));
      end
      // ethernet crc32, reflected, bit at a time
      crc = 32'hffffffff;
      foreach (exp_q[i]) begin
         crc = crc ^ {24'h0, exp_q[i]};
         for (int b = 0; b < 8; b++)
            crc = crc[0] ? ((crc >> 1) ^ pktgen_pkg::crc_poly_rev) : (crc >> 1);
      end
      crc = ~crc;
      for (int i = 0; i < 4; i++) exp_q.push_back(crc[8*i +: 8]);  // low byte first
   endtask

   task automatic compare_frame(input int seq);
      build_frame(seq);
      check_value($sformatf("frame %0d length", seq), exp_q.size(), rx_q.size());
      foreach (rx_q[i]) begin
         if (i < exp_q.size() && rx_q[i] !== exp_q[i]) begin
            check_value($sformatf("frame %0d byte %0d", seq, i), 32'(exp_q[i]), 32'(rx_q[i]));
            break;                                       // first bad byte is enough
         end
      end
      frames_checked++;
   endtask

   // --------------------------------------------------
   // monitor on tx, bytes collected on transfers only
   // --------------------------------------------------
   always @(posedge reset) begin : monitor
      int nb;
      if (!clk) begin
         if (gap_due && tx.valid) report_protocol("no idle cycle after end of frame");
         gap_due = 1'b0;
         if (tx.valid && tx_ready) begin
            if (tx.sop) begin
               if (in_frame) report_protocol("start of packet inside a frame");
               rx_q.delete();
               in_frame = 1'b1;
            end else if (!in_frame) begin
               report_protocol("beat outside a frame");
            end
            nb = tx.eop ? 8 - int'(tx.empty) : 8;
            for (int i = 0; i < nb; i++) rx_q.push_back(tx.data[63-8*i -: 8]);
            if (tx.eop) begin
               in_frame = 1'b0;
               gap_due  = 1'b1;
               compare_frame(frames_seen - frames_base);
               frames_seen <= frames_seen + 1;           // main sees it one edge later
            end
         end
      end
   end

   // host bus tasks, both start right after a clock edge
   task automatic reg_write(input logic [pktgen_pkg::addr_w-1:0] a, input logic [31:0] d);
      address   <= a;
      writedata <= d;
      write     <= 1'b1;
      @(posedge reset);
      write     <= 1'b0;
   endtask

   task automatic reg_read(input logic [pktgen_pkg::addr_w-1:0] a, output logic [31:0] d);
      address <= a;
      read    <= 1'b1;
      @(posedge reset);
      read    <= 1'b0;
      @(posedge reset);
      d = readdata;                                      // loaded one edge ago
   endtask

   initial begin : watchdog
      wait (limit_ns > 0);
      #(limit_ns);
      $display("timeout: generator still running after %0d ns", limit_ns);
      $display("sim failed");
      $finish;
   end

   initial begin : main
      int          fd;
      string       line;
      string       nm;
      int          num;
      int          len;
      int          rnd;
      int          stp;
      logic [31:0] sd;
      logic [31:0] rd;
      int          beats;
      int          exp_frames;
      logic        stop_sent;
      fd = $fopen("verification/pktgen_cases.txt", "r");
      if (fd == 0) begin
         report_protocol("cannot open verification/pktgen_cases.txt");
      end else begin
         while ($fgets(line, fd) > 0) begin
            if (line.len() > 1 && line.getc(0) != "#" &&
                $sscanf(line, "%s %d %d %d %h %d", nm, num, len, rnd, sd, stp) == 6) begin
               c_name.push_back(nm);
               c_num.push_back(num);
               c_len.push_back(len);
               c_rnd.push_back(rnd);
               c_seed.push_back(sd);
               c_stop.push_back(stp);
            end
         end
         $fclose(fd);
      end
      if (c_name.size() == 0) report_protocol("no cases were read");
      // 4x for back-pressure, 4 ns per beat, plus setup and drain per case
      beats = 0;
      foreach (c_num[i])
         beats += frames_for(c_num[i], c_stop[i]) * ((clamp_len(c_len[i]) + 27) / 8 + 2);
      limit_ns = beats * 4 * 4 + 500 * c_name.size() + 1000;

      repeat (3) @(posedge reset);
      clk <= 1'b0;
      @(posedge reset);

      foreach (c_name[k]) begin
         cur_name    = c_name[k];
         cur_plen    = clamp_len(c_len[k]);
         cur_rnd     = (c_rnd[k] != 0);
         cur_seed    = c_seed[k][22:0];
         cur_da      = {16'($random(seed)), 32'($random(seed))};
         cur_sa      = {16'($random(seed)), 32'($random(seed))};
         exp_frames  = frames_for(c_num[k], c_stop[k]);
         frames_base = frames_seen;
         stop_sent   = (c_stop[k] == 1);                 // one frame, stop goes in up front
         reg_write(pktgen_pkg::addr_num_packets, c_num[k]);
         reg_write(pktgen_pkg::addr_payload_len, c_len[k]);
         reg_write(pktgen_pkg::addr_random_payload, {31'h0, cur_rnd});
         reg_write(pktgen_pkg::addr_prbs_seed, c_seed[k]);
         reg_write(pktgen_pkg::addr_sa_lo, cur_sa[31:0]);
         reg_write(pktgen_pkg::addr_sa_hi, {16'h0, cur_sa[47:32]});
         reg_write(pktgen_pkg::addr_da_lo, cur_da[31:0]);
         reg_write(pktgen_pkg::addr_da_hi, {16'h0, cur_da[47:32]});
         reg_write(pktgen_pkg::addr_stop, stop_sent ? 32'd1 : 32'd0);
         bp_on <= 1'b1;
         reg_write(pktgen_pkg::addr_start, 32'd1);
         while (frames_seen - frames_base < exp_frames) begin
            @(posedge reset);
            // stop right after frame n-1 ends, the sequencer is then early in frame n
            if (!stop_sent && c_stop[k] > 1 && frames_seen - frames_base >= c_stop[k] - 1) begin
               stop_sent = 1'b1;
               reg_write(pktgen_pkg::addr_stop, 32'd1);
            end
         end
         bp_on <= 1'b0;
         @(posedge reset);
         rd = 32'd1;
         while (rd[0]) reg_read(pktgen_pkg::addr_start, rd);   // busy flag
         repeat (8) @(posedge reset);                           // drain the pipeline
         check_value("frames received", exp_frames, frames_seen - frames_base);
         reg_read(pktgen_pkg::addr_tx_count, rd);
         check_value("tx_count register", frames_seen - frames_base, rd);
         if (stop_sent) reg_write(pktgen_pkg::addr_stop, 32'd0);
      end

      $display("value errors %0d, protocol errors %0d, frames checked %0d",
               value_errors, proto_errors, frames_checked);
      if (value_errors == 0 && proto_errors == 0)
         $display("sim passed");
      else
         $display("sim failed");
      $finish;
   end

endmodule

//--- sim.f
source/pktgen_pkg.sv
source/pktgen_csr.sv
source/frame_sequencer.sv
source/payload_source.sv
source/fcs_inserter.sv
source/pktgen_top.sv
verification/pktgen_tb.sv

//--- Makefile
# Verilator build and run of the packet generator testbench
VERILATOR ?= verilator
TOP       ?= pktgen_tb
FILELIST  ?= sim.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing --timescale 1ns/1ps -j 0
PASS_MSG  ?= sim passed

SOURCES := $(filter-out +%,$(shell cat $(FILELIST)))
BIN     := $(OBJ_DIR)/V$(TOP)

.PHONY: all run clean

all: run

$(BIN): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

# the binary runs from the project root so the cases file path resolves
run: $(BIN)
	@out="$$($(BIN))"; echo "$$out"; echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)

//--- verification/pktgen_cases.txt
# name  packets  payload_len  random  seed(hex)  stop_after
# stop_after 0 sends every packet, n > 0 has the host write stop so that n frames go out
inc_min      3   8     0  000000  0
inc_short    2   3     0  000000  0
inc_fits     3   12    0  000000  0
inc_spill    3   13    0  000000  0
inc_even     2   64    0  000000  0
inc_odd      2   301   0  000000  0
inc_max      2   1500  0  000000  0
inc_over     1   2000  0  000000  0
prbs_short   4   9     1  5eed00  0
prbs_long    3   250   1  1abcde  0
prbs_spill   5   45    1  7fffff  0
stop_first   10  20    0  000000  1
stop_third   10  16    1  02468a  3
